//--- Bender.yml
package:
  name: uart_monitor_decoder

sources:
  - src/monitor_pkg.sv
  - src/char_decoder.sv
  - src/command_sequencer.sv
  - src/hex_word_assembler.sv
  - src/uart_monitor_decoder.sv
  - target: test
    files:
      - verification/tb_uart_monitor_decoder.sv

//--- sim.f
src/monitor_pkg.sv
src/char_decoder.sv
src/command_sequencer.sv
src/hex_word_assembler.sv
src/uart_monitor_decoder.sv
verification/tb_uart_monitor_decoder.sv

//--- src/char_decoder.sv
/*
 * char_decoder: received byte capture and character classification
 */
`timescale 1ns/10ps

module char_decoder (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [monitor_pkg::CHAR_W-1:0]   rout,
	input  logic                             rout_en,
	output logic                             char_valid,
	output monitor_pkg::char_class_e         char_class,
	output logic [monitor_pkg::NIBBLE_W-1:0] nibble
);

	// offset so that 'a' maps to 10
	localparam logic [monitor_pkg::CHAR_W-1:0] ALPHA_BASE = monitor_pkg::CHAR_HEX_LO - 10;

	logic [monitor_pkg::CHAR_W-1:0] rx_byte;
	logic [monitor_pkg::CHAR_W-1:0] alpha_value;

	// hold last character until the next strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_byte <= '0;
		end else if (rout_en) begin
			rx_byte <= rout;
		end
	end

	// strobe delayed to line up with rx_byte
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			char_valid <= 1'b0;
		end else begin
			char_valid <= rout_en;
		end
	end

	assign alpha_value = rx_byte - ALPHA_BASE;

	always_comb begin
		char_class = monitor_pkg::CLS_NONE;
		nibble     = '0;
		if (rx_byte >= monitor_pkg::CHAR_DIGIT_LO && rx_byte <= monitor_pkg::CHAR_DIGIT_HI) begin
			// '0'..'9' carry their value in the low nibble
			char_class = monitor_pkg::CLS_HEX;
			nibble     = rx_byte[monitor_pkg::NIBBLE_W-1:0];
		end else if (rx_byte >= monitor_pkg::CHAR_HEX_LO && rx_byte <= monitor_pkg::CHAR_HEX_HI) begin
			char_class = monitor_pkg::CLS_HEX;
			nibble     = alpha_value[monitor_pkg::NIBBLE_W-1:0];
		end else begin
			case (rx_byte)
				monitor_pkg::CHAR_GO:         char_class = monitor_pkg::CLS_GO;
				monitor_pkg::CHAR_QUIT:       char_class = monitor_pkg::CLS_QUIT;
				monitor_pkg::CHAR_WRITE:      char_class = monitor_pkg::CLS_WRITE;
				monitor_pkg::CHAR_READ:       char_class = monitor_pkg::CLS_READ;
				monitor_pkg::CHAR_TRASH:      char_class = monitor_pkg::CLS_TRASH;
				monitor_pkg::CHAR_INST_WRITE: char_class = monitor_pkg::CLS_INST_WRITE;
				monitor_pkg::CHAR_PC_PRINT:   char_class = monitor_pkg::CLS_PC_PRINT;
				monitor_pkg::CHAR_CR:         char_class = monitor_pkg::CLS_CR;
				// uppercase and unknown characters fall through
				default:                      char_class = monitor_pkg::CLS_NONE;
			endcase
		end
	end

endmodule

//--- src/command_sequencer.sv
/*
 * command_sequencer: monitor command FSM, control strobes,
 * line-break pulse and delayed cpu_start
 */
`timescale 1ns/10ps

module command_sequencer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     char_valid,
	input  monitor_pkg::char_class_e char_class,
	input  logic                     word_valid,
	input  logic                     dump_running,
	input  logic                     trash_running,
	output logic                     digit_take,
	output logic                     word_clear,
	output logic                     cpu_start,
	output logic                     write_address_set,
	output logic                     write_data_en,
	output logic                     read_start_set,
	output logic                     read_end_set,
	output logic                     read_stop,
	output logic                     start_trash,
	output logic                     quit_cmd,
	output logic                     inst_address_set,
	output logic                     inst_data_en,
	output logic                     pc_print,
	output logic                     pc_print_sel,
	output logic                     crlf_in
);

	monitor_pkg::cmd_state_e state;
	monitor_pkg::cmd_state_e state_next;

	logic cmd_quit;
	logic cmd_cr;
	logic cmd_hex;
	logic st_idle;
	logic collecting;
	logic go_done;
	logic word_crlf;
	logic [monitor_pkg::START_DELAY-1:0] go_dly;

	// qualified character classes
	assign cmd_quit = char_valid && (char_class == monitor_pkg::CLS_QUIT);
	assign cmd_cr   = char_valid && (char_class == monitor_pkg::CLS_CR);
	assign cmd_hex  = char_valid && (char_class == monitor_pkg::CLS_HEX);

	always_comb begin
		state_next = state;
		if (cmd_quit) begin
			// ctrl-c wins from any state
			state_next = monitor_pkg::ST_IDLE;
		end else begin
			case (state)
				monitor_pkg::ST_IDLE: begin
					if (char_valid) begin
						case (char_class)
							monitor_pkg::CLS_PC_PRINT:   state_next = monitor_pkg::ST_PC_PRINT;
							monitor_pkg::CLS_GO:         state_next = monitor_pkg::ST_GO_ADDR;
							monitor_pkg::CLS_WRITE:      state_next = monitor_pkg::ST_WR_ADDR;
							monitor_pkg::CLS_READ:       state_next = monitor_pkg::ST_RD_START;
							monitor_pkg::CLS_TRASH:      state_next = monitor_pkg::ST_TRASH;
							monitor_pkg::CLS_INST_WRITE: state_next = monitor_pkg::ST_INST_ADDR;
							default:                     state_next = monitor_pkg::ST_IDLE;
						endcase
					end
				end
				monitor_pkg::ST_GO_ADDR:
					if (word_valid) state_next = monitor_pkg::ST_GO_RUN;
				monitor_pkg::ST_WR_ADDR:
					if (word_valid) state_next = monitor_pkg::ST_WR_DATA;
				monitor_pkg::ST_RD_START:
					if (word_valid) state_next = monitor_pkg::ST_RD_END;
				monitor_pkg::ST_RD_END:
					if (word_valid) state_next = monitor_pkg::ST_RD_DUMP;
				monitor_pkg::ST_INST_ADDR:
					if (word_valid) state_next = monitor_pkg::ST_INST_DATA;
				// dump engine done, back to idle
				monitor_pkg::ST_RD_DUMP, monitor_pkg::ST_PC_PRINT:
					if (!dump_running) state_next = monitor_pkg::ST_IDLE;
				monitor_pkg::ST_TRASH:
					if (!trash_running) state_next = monitor_pkg::ST_IDLE;
				// go run and data states only leave on quit
				default: state_next = state;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= monitor_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign st_idle    = (state == monitor_pkg::ST_IDLE);
	assign collecting = (state inside {monitor_pkg::ST_GO_ADDR, monitor_pkg::ST_WR_ADDR,
		monitor_pkg::ST_WR_DATA, monitor_pkg::ST_RD_START, monitor_pkg::ST_RD_END,
		monitor_pkg::ST_INST_ADDR, monitor_pkg::ST_INST_DATA});

	// to the word assembler
	assign digit_take = cmd_hex && collecting;
	assign word_clear = cmd_quit || (st_idle && (state_next inside {monitor_pkg::ST_GO_ADDR,
		monitor_pkg::ST_WR_ADDR, monitor_pkg::ST_RD_START, monitor_pkg::ST_INST_ADDR}));

	// word strobes, one per collecting state
	assign write_address_set = word_valid && (state == monitor_pkg::ST_WR_ADDR);
	assign write_data_en     = word_valid && (state == monitor_pkg::ST_WR_DATA);
	assign read_start_set    = word_valid && (state == monitor_pkg::ST_RD_START);
	assign read_end_set      = word_valid && (state == monitor_pkg::ST_RD_END);
	assign inst_address_set  = word_valid && (state == monitor_pkg::ST_INST_ADDR);
	assign inst_data_en      = word_valid && (state == monitor_pkg::ST_INST_DATA);

	// command strobes
	assign read_stop    = cmd_quit && (state == monitor_pkg::ST_RD_DUMP);
	assign quit_cmd     = cmd_quit;
	assign start_trash  = st_idle && (state_next == monitor_pkg::ST_TRASH);
	assign pc_print     = st_idle && (state_next == monitor_pkg::ST_PC_PRINT);
	assign pc_print_sel = (state == monitor_pkg::ST_PC_PRINT);

	// completed addresses that end a line
	assign go_done   = (state == monitor_pkg::ST_GO_ADDR) && (state_next == monitor_pkg::ST_GO_RUN);
	assign word_crlf = go_done || write_address_set || read_end_set || inst_address_set;
	assign crlf_in   = word_crlf || cmd_quit || cmd_cr || start_trash || pc_print;

	// give the terminal time for the line break before running
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			go_dly <= '0;
		end else begin
			go_dly <= {go_dly[monitor_pkg::START_DELAY-2:0], go_done};
		end
	end

	assign cpu_start = go_dly[monitor_pkg::START_DELAY-1];

	// ctrl-c lands in idle on the next cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		cmd_quit |=> (state == monitor_pkg::ST_IDLE))
		else $error("quit did not return the FSM to idle");

	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({write_address_set, write_data_en, read_start_set, read_end_set,
			inst_address_set, inst_data_en}))
		else $error("more than one word strobe active");

endmodule

//--- src/hex_word_assembler.sv
/*
 * hex_word_assembler: nibble shift register, digit counter,
 * word-complete pulse and output word
 */
`timescale 1ns/10ps

module hex_word_assembler #(
	parameter int WORD_WIDTH = 32
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             digit_take,
	input  logic                             word_clear,
	input  logic [monitor_pkg::NIBBLE_W-1:0] nibble,
	output logic                             word_valid,
	output logic [WORD_WIDTH-1:0]            uart_data
);

	// hex digits per word
	localparam int DIGITS = WORD_WIDTH / monitor_pkg::NIBBLE_W;
	localparam int CNT_W  = (DIGITS > 1) ? $clog2(DIGITS) : 1;
	localparam logic [CNT_W-1:0] LAST_DIGIT = CNT_W'(DIGITS - 1);

	logic [WORD_WIDTH-1:0] work_word;
	logic [WORD_WIDTH-1:0] shifted_word;
	logic [CNT_W-1:0]      digit_cnt;
	logic                  word_valid_pre;

	// msd first so each new nibble enters at the bottom
	assign shifted_word   = {work_word[WORD_WIDTH-monitor_pkg::NIBBLE_W-1:0], nibble};
	assign word_valid_pre = digit_take && (digit_cnt == LAST_DIGIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			work_word <= '0;
		end else if (word_clear) begin
			work_word <= '0;
		end else if (digit_take) begin
			work_word <= shifted_word;
		end
	end

	// wraps straight to zero after the last digit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_cnt <= '0;
		end else if (word_clear) begin
			digit_cnt <= '0;
		end else if (digit_take) begin
			if (digit_cnt == LAST_DIGIT) begin
				digit_cnt <= '0;
			end else begin
				digit_cnt <= digit_cnt + 1'b1;
			end
		end
	end

	// completed word held until the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_data <= '0;
		end else if (word_valid_pre) begin
			uart_data <= shifted_word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= word_valid_pre;
		end
	end

	// a word needs several digits, so never back to back
	assert property (@(posedge clk) disable iff (!rst_n)
		word_valid |=> !word_valid)
		else $error("word_valid high on two consecutive cycles");

endmodule

//--- src/monitor_pkg.sv
/*
 * shared definitions for the monitor command decoder
 * character codes, widths, character classes and command states
 */
package monitor_pkg;

	// widths of a received character and of one hex digit
	localparam int CHAR_W   = 8;
	localparam int NIBBLE_W = 4;

	// command letters
	localparam logic [CHAR_W-1:0] CHAR_GO         = 8'h67;
	localparam logic [CHAR_W-1:0] CHAR_WRITE      = 8'h77;
	localparam logic [CHAR_W-1:0] CHAR_READ       = 8'h72;
	localparam logic [CHAR_W-1:0] CHAR_TRASH      = 8'h74;
	localparam logic [CHAR_W-1:0] CHAR_INST_WRITE = 8'h69;
	localparam logic [CHAR_W-1:0] CHAR_PC_PRINT   = 8'h6a;
	// ctrl-c and carriage return
	localparam logic [CHAR_W-1:0] CHAR_QUIT       = 8'h03;
	localparam logic [CHAR_W-1:0] CHAR_CR         = 8'h0d;

	// hex digit ranges, lowercase only
	localparam logic [CHAR_W-1:0] CHAR_DIGIT_LO   = 8'h30;
	localparam logic [CHAR_W-1:0] CHAR_DIGIT_HI   = 8'h39;
	localparam logic [CHAR_W-1:0] CHAR_HEX_LO     = 8'h61;
	localparam logic [CHAR_W-1:0] CHAR_HEX_HI     = 8'h66;

	// cycles from completed goto address to cpu_start
	localparam int START_DELAY = 3;

	typedef enum logic [3:0] {
		CLS_NONE, CLS_HEX, CLS_GO, CLS_QUIT, CLS_WRITE,
		CLS_READ, CLS_TRASH, CLS_INST_WRITE, CLS_PC_PRINT, CLS_CR
	} char_class_e;

	// address/data collection, then run or dump states
	typedef enum logic [3:0] {
		ST_IDLE, ST_GO_ADDR, ST_GO_RUN, ST_WR_ADDR, ST_WR_DATA,
		ST_RD_START, ST_RD_END, ST_RD_DUMP, ST_TRASH,
		ST_INST_ADDR, ST_INST_DATA, ST_PC_PRINT
	} cmd_state_e;

endpackage

//--- src/uart_monitor_decoder.sv
/*
 * uart_monitor_decoder: top level of the monitor command decoder
 */
`timescale 1ns/10ps

module uart_monitor_decoder #(
	parameter int WORD_WIDTH = 32
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [monitor_pkg::CHAR_W-1:0] rout,
	input  logic                           rout_en,
	input  logic                           dump_running,
	input  logic                           trash_running,
	output logic [WORD_WIDTH-1:0]          uart_data,
	output logic                           cpu_start,
	output logic                           write_address_set,
	output logic                           write_data_en,
	output logic                           read_start_set,
	output logic                           read_end_set,
	output logic                           read_stop,
	output logic                           start_trash,
	output logic                           quit_cmd,
	output logic                           inst_address_set,
	output logic                           inst_data_en,
	output logic                           pc_print,
	output logic                           pc_print_sel,
	output logic                           crlf_in
);

	// decoder to sequencer and assembler
	logic                             char_valid;
	monitor_pkg::char_class_e         char_class;
	logic [monitor_pkg::NIBBLE_W-1:0] nibble;
	// sequencer and assembler handshake
	logic                             digit_take;
	logic                             word_clear;
	logic                             word_valid;

	char_decoder u_char_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.rout       (rout),
		.rout_en    (rout_en),
		.char_valid (char_valid),
		.char_class (char_class),
		.nibble     (nibble)
	);

	command_sequencer u_command_sequencer (
		.clk               (clk),
		.rst_n             (rst_n),
		.char_valid        (char_valid),
		.char_class        (char_class),
		.word_valid        (word_valid),
		.dump_running      (dump_running),
		.trash_running     (trash_running),
		.digit_take        (digit_take),
		.word_clear        (word_clear),
		.cpu_start         (cpu_start),
		.write_address_set (write_address_set),
		.write_data_en     (write_data_en),
		.read_start_set    (read_start_set),
		.read_end_set      (read_end_set),
		.read_stop         (read_stop),
		.start_trash       (start_trash),
		.quit_cmd          (quit_cmd),
		.inst_address_set  (inst_address_set),
		.inst_data_en      (inst_data_en),
		.pc_print          (pc_print),
		.pc_print_sel      (pc_print_sel),
		.crlf_in           (crlf_in)
	);

	hex_word_assembler #(
		.WORD_WIDTH (WORD_WIDTH)
	) u_hex_word_assembler (
		.clk        (clk),
		.rst_n      (rst_n),
		.digit_take (digit_take),
		.word_clear (word_clear),
		.nibble     (nibble),
		.word_valid (word_valid),
		.uart_data  (uart_data)
	);

endmodule

//--- verification/tb_uart_monitor_decoder.sv
/*
 * testbench for the monitor command decoder
 * stimulus tasks, reference word function, strobe checker, watchdog
 */
`timescale 1ns/10ps

module tb_uart_monitor_decoder;

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 16;
	// characters sent over all tests, rounded up
	localparam int TEST_CHARS    = 160;
	localparam int MARGIN_CYCLES = 120;
	localparam int NUM_STROBES   = 12;

	// strobe vector positions
	localparam int I_CPU_START  = 0;
	localparam int I_WR_ADDR    = 1;
	localparam int I_WR_DATA    = 2;
	localparam int I_RD_START   = 3;
	localparam int I_RD_END     = 4;
	localparam int I_RD_STOP    = 5;
	localparam int I_TRASH      = 6;
	localparam int I_QUIT       = 7;
	localparam int I_INST_ADDR  = 8;
	localparam int I_INST_DATA  = 9;
	localparam int I_PC_PRINT   = 10;
	localparam int I_CRLF       = 11;

	logic        clk;
	logic        rst_n;
	logic [7:0]  rout;
	logic        rout_en;
	logic        dump_running;
	logic        trash_running;
	logic [31:0] uart_data;
	logic        cpu_start;
	logic        write_address_set;
	logic        write_data_en;
	logic        read_start_set;
	logic        read_end_set;
	logic        read_stop;
	logic        start_trash;
	logic        quit_cmd;
	logic        inst_address_set;
	logic        inst_data_en;
	logic        pc_print;
	logic        pc_print_sel;
	logic        crlf_in;

	logic [NUM_STROBES-1:0] strobes;
	logic                   word_strobe;

	integer      seed;
	int          errors;
	int          checks;
	int          cycle;
	int          go_crlf_cycle;
	bit          go_pending;
	bit          go_armed;
	int          exp_cnt[NUM_STROBES];
	int          act_cnt[NUM_STROBES];
	// words expected on the next word strobe or goto line break
	logic [31:0] exp_words[$];
	monitor_pkg::cmd_state_e stuck_state;

	uart_monitor_decoder #(
		.WORD_WIDTH (32)
	) u_uart_monitor_decoder (
		.clk               (clk),
		.rst_n             (rst_n),
		.rout              (rout),
		.rout_en           (rout_en),
		.dump_running      (dump_running),
		.trash_running     (trash_running),
		.uart_data         (uart_data),
		.cpu_start         (cpu_start),
		.write_address_set (write_address_set),
		.write_data_en     (write_data_en),
		.read_start_set    (read_start_set),
		.read_end_set      (read_end_set),
		.read_stop         (read_stop),
		.start_trash       (start_trash),
		.quit_cmd          (quit_cmd),
		.inst_address_set  (inst_address_set),
		.inst_data_en      (inst_data_en),
		.pc_print          (pc_print),
		.pc_print_sel      (pc_print_sel),
		.crlf_in           (crlf_in)
	);

	assign strobes = {crlf_in, pc_print, inst_data_en, inst_address_set, quit_cmd,
		start_trash, read_stop, read_end_set, read_start_set, write_data_en,
		write_address_set, cpu_start};
	assign word_strobe = write_address_set || write_data_en || read_start_set ||
		read_end_set || inst_address_set || inst_data_en;

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic string strobe_name(input int idx);
		case (idx)
			I_CPU_START: return "cpu_start";
			I_WR_ADDR:   return "write_address_set";
			I_WR_DATA:   return "write_data_en";
			I_RD_START:  return "read_start_set";
			I_RD_END:    return "read_end_set";
			I_RD_STOP:   return "read_stop";
			I_TRASH:     return "start_trash";
			I_QUIT:      return "quit_cmd";
			I_INST_ADDR: return "inst_address_set";
			I_INST_DATA: return "inst_data_en";
			I_PC_PRINT:  return "pc_print";
			default:     return "crlf_in";
		endcase
	endfunction

	// value of the lowercase hex digits in a string, msd first, others skipped
	function automatic logic [31:0] hex_word_of(input string text);
		logic [7:0]  c;
		logic [3:0]  d;
		logic [31:0] v;
		bit          ok;
		v = '0;
		for (int k = 0; k < text.len(); k++) begin
			c  = text[k];
			ok = 1'b1;
			d  = '0;
			if (c >= "0" && c <= "9") begin
				d = 4'(c - "0");
			end else if (c >= "a" && c <= "f") begin
				d = 4'(c - "a" + 10);
			end else begin
				ok = 1'b0;
			end
			if (ok) begin
				v = {v[27:0], d};
			end
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] t=%0t ns %s: expected %h, actual %h", $time, name, expected,
				actual);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("error at t=%0t ns: %s", $time, msg);
	endtask

	// called right after a rising edge, returns right after one
	task automatic send_char(input logic [7:0] c);
		rout    <= c;
		rout_en <= 1'b1;
		@(posedge clk);
		rout_en <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic send_text(input string text, input bit expect_word);
		if (expect_word) begin
			exp_words.push_back(hex_word_of(text));
		end
		for (int k = 0; k < text.len(); k++) begin
			send_char(text[k]);
		end
	endtask

	task automatic send_word(input logic [31:0] w, input bit expect_word);
		send_text($sformatf("%08h", w), expect_word);
	endtask

	task automatic sample_pc_print_sel(input logic expected);
		@(negedge clk);
		check_value("pc_print_sel", expected, pc_print_sel);
		@(posedge clk);
	endtask

	// address, three data words, quit, then stray digits
	task automatic write_sequence(input logic [7:0] cmd, input int addr_idx,
		input int data_idx);
		send_char(cmd);
		send_word($random(seed), 1'b1);
		exp_cnt[addr_idx]++;
		exp_cnt[I_CRLF]++;
		repeat (3) begin
			send_word($random(seed), 1'b1);
			exp_cnt[data_idx]++;
		end
		send_char(monitor_pkg::CHAR_QUIT);
		exp_cnt[I_QUIT]++;
		exp_cnt[I_CRLF]++;
		send_word($random(seed), 1'b0);
	endtask

	task automatic read_sequence(input bit stop_by_quit);
		dump_running <= 1'b1;
		send_char(monitor_pkg::CHAR_READ);
		send_word($random(seed), 1'b1);
		exp_cnt[I_RD_START]++;
		send_word($random(seed), 1'b1);
		exp_cnt[I_RD_END]++;
		exp_cnt[I_CRLF]++;
		repeat (2) @(posedge clk);
		if (stop_by_quit) begin
			send_char(monitor_pkg::CHAR_QUIT);
			exp_cnt[I_RD_STOP]++;
			exp_cnt[I_QUIT]++;
			exp_cnt[I_CRLF]++;
			dump_running <= 1'b0;
		end else begin
			dump_running <= 1'b0;
			repeat (2) @(posedge clk);
			// accepted only from idle
			send_char(monitor_pkg::CHAR_TRASH);
			exp_cnt[I_TRASH]++;
			exp_cnt[I_CRLF]++;
		end
	endtask

	// strobe checker, mid-cycle sampling
	always @(negedge clk) begin
		if (rst_n) begin
			cycle = cycle + 1;
			for (int i = 0; i < NUM_STROBES; i++) begin
				if (strobes[i]) begin
					act_cnt[i]++;
				end
			end
			if (word_strobe) begin
				if (exp_words.size() == 0) begin
					report_problem("word strobe with no word expected");
				end else begin
					check_value("uart_data", exp_words.pop_front(), uart_data);
				end
			end
			// goto address has no strobe of its own, only the line break
			if (crlf_in && go_pending) begin
				if (exp_words.size() == 0) begin
					report_problem("goto line break with no address expected");
				end else begin
					check_value("uart_data", exp_words.pop_front(), uart_data);
				end
				go_crlf_cycle = cycle;
				go_pending    = 1'b0;
				go_armed      = 1'b1;
			end
			if (cpu_start) begin
				if (go_armed) begin
					check_value("cpu_start delay", monitor_pkg::START_DELAY,
						cycle - go_crlf_cycle);
					go_armed = 1'b0;
				end else begin
					report_problem("cpu_start without a completed goto address");
				end
			end
		end
	end

	initial begin
		#((RESET_CYCLES + TEST_CHARS * 3 + MARGIN_CYCLES) * CLK_PERIOD);
		stuck_state = u_uart_monitor_decoder.u_command_sequencer.state;
		$display("watchdog: run timed out at t=%0t ns with the FSM in %s", $time,
			stuck_state.name());
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		rout          = '0;
		rout_en       = 1'b0;
		dump_running  = 1'b0;
		trash_running = 1'b0;
		seed          = 32'hbe83_d57f;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// quiet outputs straight after reset
		@(negedge clk);
		for (int i = 0; i < NUM_STROBES; i++) begin
			check_value(strobe_name(i), 1'b0, strobes[i]);
		end
		check_value("pc_print_sel", 1'b0, pc_print_sel);
		check_value("uart_data", 32'h0, uart_data);
		@(posedge clk);

		write_sequence(monitor_pkg::CHAR_WRITE, I_WR_ADDR, I_WR_DATA);
		write_sequence(monitor_pkg::CHAR_INST_WRITE, I_INST_ADDR, I_INST_DATA);

		// goto, then quit out of the run state
		send_char(monitor_pkg::CHAR_GO);
		go_pending = 1'b1;
		send_word($random(seed), 1'b1);
		exp_cnt[I_CRLF]++;
		exp_cnt[I_CPU_START]++;
		repeat (monitor_pkg::START_DELAY + 2) @(posedge clk);
		send_char(monitor_pkg::CHAR_QUIT);
		exp_cnt[I_QUIT]++;
		exp_cnt[I_CRLF]++;

		read_sequence(1'b1);
		read_sequence(1'b0);

		// trash with the clearing engine busy for a while
		trash_running <= 1'b1;
		send_char(monitor_pkg::CHAR_TRASH);
		exp_cnt[I_TRASH]++;
		exp_cnt[I_CRLF]++;
		repeat (3) @(posedge clk);
		trash_running <= 1'b0;
		repeat (2) @(posedge clk);

		dump_running <= 1'b1;
		send_char(monitor_pkg::CHAR_PC_PRINT);
		exp_cnt[I_PC_PRINT]++;
		exp_cnt[I_CRLF]++;
		repeat (4) sample_pc_print_sel(1'b1);
		dump_running <= 1'b0;
		@(posedge clk);
		sample_pc_print_sel(1'b0);

		// uppercase and unknown characters in idle and inside a word
		send_text("xABCDEF", 1'b0);
		send_char(monitor_pkg::CHAR_WRITE);
		send_text("aZ1B2?c3D4e5F", 1'b1);
		exp_cnt[I_WR_ADDR]++;
		exp_cnt[I_CRLF]++;
		send_char(monitor_pkg::CHAR_QUIT);
		exp_cnt[I_QUIT]++;
		exp_cnt[I_CRLF]++;
		send_char(monitor_pkg::CHAR_CR);
		exp_cnt[I_CRLF]++;

		repeat (monitor_pkg::START_DELAY + 2) @(posedge clk);
		for (int i = 0; i < NUM_STROBES; i++) begin
			check_value({strobe_name(i), " count"}, exp_cnt[i], act_cnt[i]);
		end
		if (exp_words.size() != 0) begin
			report_problem("expected words never appeared on uart_data");
		end
		if (go_pending || go_armed) begin
			report_problem("goto line break or cpu_start never came");
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
